// File: bench/calc_tb.sv
`timescale 1ns/10ps

module calc_tb;

    localparam int N_EQ       = 40;
    localparam int N_DIRECTED = 11;
    localparam int MAX_DIGITS = 7;
    localparam int EQ_CYCLES  = 2 * MAX_DIGITS + calc_pkg::MUL_CYCLES + 12;
    localparam int TIMEOUT    = N_EQ * EQ_CYCLES + 5 + 100;    // Plus reset and drain

    logic                                   clk;
    logic                                   nRST;
    logic [calc_pkg::DIGIT_W-1:0]           keypad_input;
    logic                                   read_input;
    logic [2:0]                             operator_input;
    logic                                   equal_input;
    logic                                   complete;
    logic signed [calc_pkg::OPERAND_W-1:0]  display_output;

    logic signed [calc_pkg::OPERAND_W-1:0]  model_q [$];    // Expected results in order
    logic signed [calc_pkg::OPERAND_W-1:0]  exp_head;
    logic                                   exp_avail;
    logic                                   eq_seen;
    logic [31:0]                            rng_state;
    int                                     n_sent;
    int                                     n_done;
    int                                     n_held;
    int                                     cycles;

    calc_top UUT (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int unsigned pow10(input int n);
        int unsigned p;
        p = 1;
        for (int i = 0; i < n; i++)
            p = p * 10;
        return p;
    endfunction

    // Codes that are not one-hot and must not end phase A
    function automatic logic [2:0] bad_code(input logic [31:0] r);
        case (r % 3)
            0:       return 3'b000;
            1:       return 3'b011;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [15:0] expected_result(input logic [2:0] op,
                                                    input logic [15:0] a, input logic [15:0] b);
        logic [31:0] r;
        case (op)
            calc_pkg::OP_ADD: r = {16'd0, a} + {16'd0, b};
            calc_pkg::OP_SUB: r = {16'd0, a} - {16'd0, b};
            default:          r = {16'd0, a} * {16'd0, b};
        endcase
        return r[15:0];    // Low word, read as signed
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic key_cycle(input logic rd, input logic [3:0] digit,
                             input logic [2:0] code);
        read_input     = rd;
        keypad_input   = digit;
        operator_input = code;
        equal_input    = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic key_number(input int unsigned value, input int ndig, input logic noisy,
                              output logic [15:0] operand);
        logic [31:0] digit;
        logic [31:0] acc;
        logic [2:0]  code;
        operand = '0;
        for (int i = ndig - 1; i >= 0; i--) begin
            digit = (value / pow10(i)) % 10;
            code  = noisy ? bad_code(next_rand()) : 3'b000;
            key_cycle(1'b1, digit[3:0], code);
            acc     = {16'd0, operand} * 32'd10 + digit;
            operand = acc[15:0];    // Entry wraps at the word width
        end
    endtask

    task automatic key_equation(input int unsigned a, input int na, input logic [2:0] op,
                                input int unsigned b, input int nb, input logic noisy);
        logic [15:0] opa;
        logic [15:0] opb;
        logic        held;
        key_number(a, na, noisy, opa);
        key_cycle(1'b0, 4'd0, op);
        key_number(b, nb, 1'b0, opb);
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b1;
        eq_seen        = 1'b1;
        held           = UUT.full;    // Seen by the entry on the coming edge
        model_q.push_back(expected_result(op, opa, opb));
        n_sent++;
        @(posedge clk);
        #1;
        equal_input = 1'b0;
        if (held)
            n_held++;
        while (held) begin    // Keys are ignored until the request is pushed
            held = UUT.full;
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        exp_avail = (model_q.size() > 0);
        exp_head  = exp_avail ? model_q[0] : '0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (nRST && complete) begin
            void'(model_q.pop_front());
            n_done <= n_done + 1;
        end
        if (cycles >= TIMEOUT)
            abort_run("Timeout, equations still pending at the cycle limit");
    end

    check_result: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> (display_output == exp_head))
        else abort_run($sformatf("FAIL display_output expected %h actual %h",
                                 exp_head, $sampled(display_output)));
    check_pending: assert property (@(posedge clk) disable iff (!nRST) complete |-> exp_avail)
        else abort_run("complete pulsed with no equation waiting for a result");
    check_pulse: assert property (@(posedge clk) disable iff (!nRST) complete |=> !complete)
        else abort_run("complete stayed high for more than one cycle");
    check_hold: assert property (@(posedge clk) disable iff (!nRST)
        !complete |-> $stable(display_output))
        else abort_run("display_output changed between complete pulses");
    check_quiet: assert property (@(posedge clk) disable iff (!nRST)
        !eq_seen |-> (!complete && display_output == '0))
        else abort_run("complete or display_output active before the first equal press");

    initial begin
        logic [31:0] r;
        int unsigned a;
        int unsigned b;
        int          na;
        int          nb;
        logic [2:0]  op;
        rng_state      = 32'h9ed2d42f;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        eq_seen        = 1'b0;
        n_sent         = 0;
        n_done         = 0;
        n_held         = 0;
        cycles         = 0;
        repeat (5) @(posedge clk);
        #1;
        nRST = 1'b1;
        repeat (4) @(posedge clk);    // Quiet stretch after reset
        #1;
        key_equation(123, 3, calc_pkg::OP_ADD, 4567, 4, 1'b0);
        key_equation(12, 2, calc_pkg::OP_SUB, 345, 3, 1'b0);      // Negative result
        key_equation(65535, 5, calc_pkg::OP_ADD, 7, 1, 1'b0);     // Wraps to 6
        key_equation(999, 3, calc_pkg::OP_MUL, 999, 3, 1'b0);
        key_equation(300, 3, calc_pkg::OP_MUL, 300, 3, 1'b0);
        key_equation(1234567, 7, calc_pkg::OP_ADD, 89, 2, 1'b1);  // Long operand, bad codes
        key_equation(987654, 6, calc_pkg::OP_SUB, 3, 1, 1'b1);
        // Short equations keyed while the multiply runs
        key_equation(255, 3, calc_pkg::OP_MUL, 255, 3, 1'b0);
        key_equation(1, 1, calc_pkg::OP_ADD, 2, 1, 1'b0);
        key_equation(9, 1, calc_pkg::OP_SUB, 8, 1, 1'b0);
        key_equation(4, 1, calc_pkg::OP_ADD, 4, 1, 1'b0);
        for (int i = 0; i < N_EQ - N_DIRECTED; i++) begin
            na = 1 + int'(next_rand() % 5);
            nb = 1 + int'(next_rand() % 5);
            a  = next_rand() % pow10(na);
            b  = next_rand() % pow10(nb);
            r  = next_rand();
            op = (r % 3 == 0) ? calc_pkg::OP_ADD
               : (r % 3 == 1) ? calc_pkg::OP_SUB : calc_pkg::OP_MUL;
            key_equation(a, na, op, b, nb, r[8]);
        end
        while (n_done < n_sent) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        if (model_q.size() != 0 || n_done != N_EQ || n_held == 0)
            abort_run("Results missing at the end, or no request was ever held");
        else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: filelist.f
hw/calc_pkg.sv
hw/keypad_entry.sv
hw/request_queue.sv
hw/arith_unit.sv
hw/calc_control.sv
hw/calc_top.sv
bench/calc_tb.sv

// File: hw/arith_unit.sv
`timescale 1ns/10ps

module arith_unit (
    input  logic                                clk,
    input  logic                                nRST,
    input  logic                                start,
    input  calc_pkg::calc_op_t                  op,
    input  logic [calc_pkg::OPERAND_W-1:0]      in_a,
    input  logic [calc_pkg::OPERAND_W-1:0]      in_b,
    output logic                                finish,
    output logic signed [calc_pkg::OPERAND_W-1:0] result
);

    logic                               busy;       // Multiply in progress
    logic [calc_pkg::MUL_CNT_W-1:0]     iter;
    logic [calc_pkg::OPERAND_W-1:0]     mcand;
    logic [calc_pkg::OPERAND_W-1:0]     mplier;
    logic [calc_pkg::OPERAND_W-1:0]     acc;
    logic [calc_pkg::OPERAND_W-1:0]     acc_step;
    logic                               last_iter;

    // Partial product for the current multiplier bit, low bits only
    assign acc_step  = acc + (mplier[0] ? mcand : '0);
    assign last_iter = busy && (iter == calc_pkg::MUL_LAST_CNT);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            iter   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy   <= (op == calc_pkg::OP_MUL);
                finish <= (op != calc_pkg::OP_MUL);    // Add and sub done in one
                iter   <= calc_pkg::MUL_FIRST_CNT;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (last_iter) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Datapath, the first multiply step happens on the start edge
    always_ff @(posedge clk) begin
        if (start) begin
            case (op)
                calc_pkg::OP_ADD: result <= in_a + in_b;
                calc_pkg::OP_SUB: result <= in_a - in_b;
                default: begin
                    acc    <= in_b[0] ? in_a : '0;
                    mcand  <= in_a << 1;
                    mplier <= in_b >> 1;
                end
            endcase
        end else if (busy) begin
            acc    <= acc_step;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (last_iter)
                result <= acc_step;
        end
    end

    // The controller must wait for finish before the next start
    no_start_busy: assert property (@(posedge clk) disable iff (!nRST) start |-> !busy);

endmodule

// File: hw/calc_control.sv
`timescale 1ns/10ps

module calc_control (
    input  logic                                    clk,
    input  logic                                    nRST,
    input  logic                                    empty,
    input  calc_pkg::calc_req_t                     head_req,
    output logic                                    pop,
    output logic                                    start,
    output calc_pkg::calc_op_t                      op,
    output logic [calc_pkg::OPERAND_W-1:0]          in_a,
    output logic [calc_pkg::OPERAND_W-1:0]          in_b,
    input  logic                                    finish,
    input  logic signed [calc_pkg::OPERAND_W-1:0]   result,
    output logic                                    complete,
    output logic signed [calc_pkg::OPERAND_W-1:0]   display_output
);

    typedef enum logic [1:0] {
        IDLE,   // Waiting for a queued request
        BUSY,   // Arithmetic unit running
        SHOW    // Result on display, complete high
    } ctrl_state_t;

    ctrl_state_t state;

    assign pop = (state == IDLE) && !empty;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= IDLE;
            start          <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            start    <= 1'b0;
            complete <= 1'b0;
            case (state)
                IDLE: begin
                    if (pop) begin
                        start <= 1'b1;      // Operands latched on this edge too
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (finish) begin
                        display_output <= result;
                        complete       <= 1'b1;
                        state          <= SHOW;
                    end
                end
                SHOW:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            op   <= head_req.op;
            in_a <= head_req.operand_a;
            in_b <= head_req.operand_b;
        end
    end

    finish_when_busy: assert property (@(posedge clk) disable iff (!nRST)
        finish |-> (state == BUSY));

endmodule

// File: hw/calc_pkg.sv
package calc_pkg;

    // Word and keypad sizes
    localparam int OPERAND_W = 16;
    localparam int DIGIT_W   = 4;

    // Request buffer sizing, depth kept a power of two
    localparam int QUEUE_DEPTH = 2;
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);
    localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);

    localparam logic [CNT_W-1:0] QUEUE_FULL_CNT = QUEUE_DEPTH[CNT_W-1:0];

    // Shift-add multiplier, one iteration per multiplier bit
    localparam int MUL_CYCLES = OPERAND_W;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);
    localparam int MUL_LAST   = MUL_CYCLES - 1;

    localparam logic [MUL_CNT_W-1:0] MUL_FIRST_CNT = 1;       // First step done at start
    localparam logic [MUL_CNT_W-1:0] MUL_LAST_CNT  = MUL_LAST[MUL_CNT_W-1:0];

    // One-hot operator codes as they arrive from the keypad
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,
        OP_SUB = 3'b010,
        OP_MUL = 3'b100
    } calc_op_t;

    // One complete equation waiting for the arithmetic unit
    typedef struct packed {
        calc_op_t               op;
        logic [OPERAND_W-1:0]   operand_a;
        logic [OPERAND_W-1:0]   operand_b;
    } calc_req_t;

endpackage

// File: hw/calc_top.sv
`timescale 1ns/10ps

module calc_top (
    input  logic                                    clk,
    input  logic                                    nRST,
    input  logic [calc_pkg::DIGIT_W-1:0]            keypad_input,
    input  logic                                    read_input,
    input  logic [2:0]                              operator_input,
    input  logic                                    equal_input,
    output logic                                    complete,
    output logic signed [calc_pkg::OPERAND_W-1:0]   display_output
);

    // Producer to queue
    logic                                   push;
    logic                                   full;
    calc_pkg::calc_req_t                    push_req;

    // Queue to consumer
    logic                                   pop;
    logic                                   empty;
    calc_pkg::calc_req_t                    head_req;

    // Consumer to arithmetic unit
    logic                                   start;
    logic                                   finish;
    calc_pkg::calc_op_t                     op;
    logic [calc_pkg::OPERAND_W-1:0]         in_a;
    logic [calc_pkg::OPERAND_W-1:0]         in_b;
    logic signed [calc_pkg::OPERAND_W-1:0]  result;

    keypad_entry u_entry (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .full           (full),
        .push           (push),
        .push_req       (push_req)
    );

    request_queue u_queue (
        .clk      (clk),
        .nRST     (nRST),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .full     (full),
        .empty    (empty),
        .head_req (head_req)
    );

    calc_control u_control (
        .clk            (clk),
        .nRST           (nRST),
        .empty          (empty),
        .head_req       (head_req),
        .pop            (pop),
        .start          (start),
        .op             (op),
        .in_a           (in_a),
        .in_b           (in_b),
        .finish         (finish),
        .result         (result),
        .complete       (complete),
        .display_output (display_output)
    );

    arith_unit u_arith (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start),
        .op     (op),
        .in_a   (in_a),
        .in_b   (in_b),
        .finish (finish),
        .result (result)
    );

endmodule

// File: hw/keypad_entry.sv
`timescale 1ns/10ps

module keypad_entry (
    input  logic                            clk,
    input  logic                            nRST,
    input  logic [calc_pkg::DIGIT_W-1:0]    keypad_input,
    input  logic                            read_input,
    input  logic [2:0]                      operator_input,
    input  logic                            equal_input,
    input  logic                            full,
    output logic                            push,
    output calc_pkg::calc_req_t             push_req
);

    typedef enum logic [1:0] {
        PHASE_A,    // Building first operand
        PHASE_B,    // Building second operand
        HOLD        // Request waits for queue room
    } entry_state_t;

    entry_state_t                   state;
    calc_pkg::calc_op_t             op_q;
    logic [calc_pkg::OPERAND_W-1:0] operand_a;
    logic [calc_pkg::OPERAND_W-1:0] operand_b;
    logic [calc_pkg::OPERAND_W-1:0] operand_b_next;
    logic                           op_valid;
    logic                           take_eq;

    // Old value times ten plus the digit, wraps at the word width
    function automatic logic [calc_pkg::OPERAND_W-1:0] fold_digit(
        input logic [calc_pkg::OPERAND_W-1:0] value,
        input logic [calc_pkg::DIGIT_W-1:0]   digit
    );
        return (value << 3) + (value << 1)
            + {{(calc_pkg::OPERAND_W - calc_pkg::DIGIT_W){1'b0}}, digit};
    endfunction

    assign op_valid = (operator_input == calc_pkg::OP_ADD)
                   || (operator_input == calc_pkg::OP_SUB)
                   || (operator_input == calc_pkg::OP_MUL);
    assign take_eq = (state == PHASE_B) && equal_input;

    // A digit keyed with equal still lands in operand B
    assign operand_b_next = read_input ? fold_digit(operand_b, keypad_input) : operand_b;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= PHASE_A;
            op_q      <= calc_pkg::OP_ADD;
            operand_a <= '0;
            operand_b <= '0;
            push      <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                PHASE_A: begin
                    if (read_input)
                        operand_a <= fold_digit(operand_a, keypad_input);
                    if (op_valid) begin
                        op_q  <= calc_pkg::calc_op_t'(operator_input);
                        state <= PHASE_B;
                    end
                end
                PHASE_B: begin
                    if (equal_input) begin
                        operand_a <= '0;
                        operand_b <= '0;
                        push      <= !full;
                        state     <= full ? HOLD : PHASE_A;
                    end else begin
                        operand_b <= operand_b_next;
                    end
                end
                HOLD: begin
                    if (!full) begin    // Keys ignored until pushed
                        push  <= 1'b1;
                        state <= PHASE_A;
                    end
                end
                default: state <= PHASE_A;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_eq) begin
            push_req.op        <= op_q;
            push_req.operand_a <= operand_a;
            push_req.operand_b <= operand_b_next;
        end
    end

    // Queue full only drops by a pop, so a registered push is always safe
    push_never_full: assert property (@(posedge clk) disable iff (!nRST) push |-> !full);

endmodule

// File: hw/request_queue.sv
`timescale 1ns/10ps

module request_queue (
    input  logic                clk,
    input  logic                nRST,
    input  logic                push,
    input  calc_pkg::calc_req_t push_req,
    input  logic                pop,
    output logic                full,
    output logic                empty,
    output calc_pkg::calc_req_t head_req
);

    calc_pkg::calc_req_t            mem [calc_pkg::QUEUE_DEPTH];
    logic [calc_pkg::PTR_W-1:0]     wr_ptr;
    logic [calc_pkg::PTR_W-1:0]     rd_ptr;
    logic [calc_pkg::CNT_W-1:0]     count;
    logic                           do_push;
    logic                           do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == calc_pkg::QUEUE_FULL_CNT);
    assign empty    = (count == '0);
    assign head_req = mem[rd_ptr];      // Head visible the cycle after its push

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_req;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps, depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    no_push_full: assert property (@(posedge clk) disable iff (!nRST) push |-> !full);
    no_pop_empty: assert property (@(posedge clk) disable iff (!nRST) pop |-> !empty);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the calculator testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --top-module calc_tb -f filelist.f -o calc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/calc_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation PASSED"
exit 0
